// File: include/mpu_consts.svh
/*
 * Matrix processing unit dispatch constants
 * Field widths and table depth shared by the dispatch front end
 */

`ifndef MPU_CONSTS_SVH
`define MPU_CONSTS_SVH

////////////////////////////////////////
// Field widths
////////////////////////////////////////
`define MPU_TID_W	4	// Thread number
`define MPU_ISSUE_W	6	// Issue number
`define MPU_ADDR_W	8	// Instruction memory address
`define MPU_LEN_W	8	// Program length, words minus one
`define MPU_DATA_W	32	// Instruction word payload

////////////////////////////////////////
// Table depth
////////////////////////////////////////
// One map entry per thread
`define MPU_THREADS	16

`endif

// File: hdl/mpu_pkg.sv
/*
 * Matrix processing unit dispatch types
 * Width typedefs, word and table structs, dispatch FSM states
 */

`default_nettype none

`include "mpu_consts.svh"

package mpu_pkg;

	// Plain vectors with a meaning
	typedef logic [`MPU_TID_W-1:0]		thread_id_t;
	typedef logic [`MPU_ISSUE_W-1:0]	issue_no_t;
	typedef logic [`MPU_ADDR_W-1:0]		mem_addr_t;
	typedef logic [`MPU_LEN_W-1:0]		prog_len_t;
	typedef logic [`MPU_DATA_W-1:0]		word_data_t;

	// Memory word and output word
	typedef struct packed {
		logic		valid;
		word_data_t	data;
	} instr_t;

	// Thread map entry, length is words minus one
	typedef struct packed {
		mem_addr_t	base;
		prog_len_t	length;
	} lookup_t;

	// Load ports
	typedef struct packed {
		logic		en;
		thread_id_t	tid;
		lookup_t	info;
	} map_write_t;

	typedef struct packed {
		logic		en;
		mem_addr_t	addr;
		instr_t		word;
	} mem_write_t;

	typedef enum logic [2:0] {
		idle,
		get_info,
		send_thread_id,
		send_issue_no,
		send_length,
		send_instrs
	} dispatch_state_t;

endpackage

`default_nettype wire

// File: hdl/thread_map.sv
/*
 * Thread map
 * Holds program base address and length per thread.
 * Answers a level lookup request with a single registered
 * acknowledge pulse and the entry for the requested thread.
 */

`timescale 1ns/10ps
`default_nettype none

`include "mpu_consts.svh"

module thread_map (
	input  wire						clock,
	input  wire						reset,
	input  mpu_pkg::map_write_t		map_write,		// Load port
	input  wire						lookup_req,		// Level from dispatcher
	input  mpu_pkg::thread_id_t		lookup_id,
	output logic					lookup_ack,		// One-cycle pulse
	output mpu_pkg::lookup_t		lookup_info
);

	mpu_pkg::lookup_t	table_q [0:`MPU_THREADS-1];
	logic				req_seen;					// Request already answered
	logic				new_req;

	// Only the first cycle of a request is answered
	assign new_req = lookup_req & ~req_seen;

	////////////////////////////////////////
	// Table storage
	////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `MPU_THREADS; i++) begin
				table_q[i] <= '0;
			end
		end
		else if (map_write.en) begin
			table_q[map_write.tid] <= map_write.info;
		end
	end

	////////////////////////////////////////
	// Lookup handshake
	////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			req_seen	<= 1'b0;
			lookup_ack	<= 1'b0;
		end
		else begin
			req_seen	<= lookup_req;			// Drops when request goes away
			lookup_ack	<= new_req;
		end
	end

	// Entry payload, valid alongside the acknowledge
	always_ff @(posedge clock) begin
		if (new_req) begin
			lookup_info <= table_q[lookup_id];
		end
	end

endmodule

`default_nettype wire

// File: hdl/instr_mem.sv
/*
 * Instruction memory
 * Word array with a synchronous write port and a registered read.
 * An idle read cycle returns a word with the valid bit low.
 */

`timescale 1ns/10ps
`default_nettype none

`include "mpu_consts.svh"

module instr_mem (
	input  wire						clock,
	input  mpu_pkg::mem_write_t		mem_write,		// Load port
	input  wire						mem_rd,
	input  mpu_pkg::mem_addr_t		mem_addr,
	output mpu_pkg::instr_t			rd_word			// One cycle after mem_rd
);

	localparam int DEPTH = 2 ** `MPU_ADDR_W;

	mpu_pkg::instr_t	mem_q [0:DEPTH-1];

	// Write side
	always_ff @(posedge clock) begin
		if (mem_write.en) begin
			mem_q[mem_write.addr] <= mem_write.word;
		end
	end

	////////////////////////////////////////
	// Read side
	////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (mem_rd) begin
			rd_word <= mem_q[mem_addr];
		end
		else begin
			rd_word <= '0;						// Empty slot
		end
	end

endmodule

`default_nettype wire

// File: hdl/thread_dispatch.sv
/*
 * Thread dispatcher
 * Accepts an issue strobe, looks up the thread's program in the
 * thread map, sends thread number, issue number and length as
 * header words, then streams the program out of instruction memory.
 * No back-pressure, a burst is always header plus L+1 words.
 */

`timescale 1ns/10ps
`default_nettype none

module thread_dispatch (
	input  wire						clock,
	input  wire						reset,
	input  wire						issue,			// One-cycle strobe
	input  mpu_pkg::thread_id_t		thread_id,
	input  mpu_pkg::issue_no_t		issue_no,
	output logic					lookup_req,		// Held until acknowledged
	output mpu_pkg::thread_id_t		lookup_id,
	input  wire						lookup_ack,
	input  mpu_pkg::lookup_t		lookup_info,
	output logic					mem_rd,
	output mpu_pkg::mem_addr_t		mem_addr,
	input  mpu_pkg::instr_t			rd_word,		// Memory word, one cycle late
	output mpu_pkg::instr_t			out_word,
	output logic					busy,
	output logic					sending,
	output logic					end_send		// Last read cycle
);

	mpu_pkg::dispatch_state_t	state;

	// Latched issue
	mpu_pkg::thread_id_t	tid_r;
	mpu_pkg::issue_no_t		issue_r;

	// Program walk
	mpu_pkg::mem_addr_t		addr_r;
	mpu_pkg::prog_len_t		count_r;				// Words still to read, minus one
	mpu_pkg::prog_len_t		len_r;					// Kept for the length header

	mpu_pkg::instr_t		hdr_word;
	logic					rd_dly;					// mem_rd delayed by memory latency
	logic					accept;
	logic					last_read;

	assign accept		= issue & (state == mpu_pkg::idle);	// Strobe dropped when busy
	assign last_read	= count_r == '0;

	assign busy			= state != mpu_pkg::idle;
	assign sending		= state == mpu_pkg::send_instrs;
	assign end_send		= sending & last_read;

	assign lookup_req	= state == mpu_pkg::get_info;
	assign lookup_id	= tid_r;

	assign mem_rd		= sending;
	assign mem_addr		= addr_r;

	////////////////////////////////////////
	// Output word
	////////////////////////////////////////
	// Header register is empty while memory words come back
	assign out_word.valid	= (rd_dly & rd_word.valid) | hdr_word.valid;
	assign out_word.data	= rd_dly ? rd_word.data : hdr_word.data;

	////////////////////////////////////////
	// Issue latch
	////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			tid_r	<= '0;
			issue_r	<= '0;
		end
		else if (accept) begin
			tid_r	<= thread_id;
			issue_r	<= issue_no;
		end
	end

	////////////////////////////////////////
	// Address, count and length
	////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			addr_r	<= '0;
			count_r	<= '0;
			len_r	<= '0;
		end
		else if (sending) begin
			addr_r	<= addr_r + 1'b1;
			count_r	<= count_r - 1'b1;
		end
		else if (lookup_ack) begin
			addr_r	<= lookup_info.base;
			count_r	<= lookup_info.length;
			len_r	<= lookup_info.length;
		end
	end

	// Header words, zero-extended to word width
	always_ff @(posedge clock) begin
		if (reset) begin
			hdr_word	<= '0;
			rd_dly		<= 1'b0;
		end
		else begin
			rd_dly		<= mem_rd;
			case (state)
				mpu_pkg::send_thread_id: begin
					hdr_word.valid	<= 1'b1;
					hdr_word.data	<= mpu_pkg::word_data_t'(tid_r);
				end
				mpu_pkg::send_issue_no: begin
					hdr_word.valid	<= 1'b1;
					hdr_word.data	<= mpu_pkg::word_data_t'(issue_r);
				end
				mpu_pkg::send_length: begin
					hdr_word.valid	<= 1'b1;
					hdr_word.data	<= mpu_pkg::word_data_t'(len_r);
				end
				default: begin
					hdr_word		<= '0;
				end
			endcase
		end
	end

	////////////////////////////////////////
	// Dispatch FSM
	////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			state <= mpu_pkg::idle;
		end
		else begin
			case (state)
				mpu_pkg::idle: begin
					if (accept) begin
						state <= mpu_pkg::get_info;
					end
				end
				mpu_pkg::get_info: begin
					if (lookup_ack) begin
						state <= mpu_pkg::send_thread_id;
					end
				end
				mpu_pkg::send_thread_id:	state <= mpu_pkg::send_issue_no;
				mpu_pkg::send_issue_no:		state <= mpu_pkg::send_length;
				mpu_pkg::send_length:		state <= mpu_pkg::send_instrs;
				mpu_pkg::send_instrs: begin
					if (last_read) begin
						state <= mpu_pkg::idle;		// Last word still in flight
					end
				end
				default: begin
					state <= mpu_pkg::idle;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hdl/mpu_dispatch.sv
/*
 * Dispatch front end, top level
 * Connects the dispatcher to the thread map and the
 * instruction memory
 */

`timescale 1ns/10ps
`default_nettype none

module mpu_dispatch (
	input  wire						clock,
	input  wire						reset,
	input  wire						issue,
	input  mpu_pkg::thread_id_t		thread_id,
	input  mpu_pkg::issue_no_t		issue_no,
	input  mpu_pkg::map_write_t		map_write,
	input  mpu_pkg::mem_write_t		mem_write,
	output mpu_pkg::instr_t			out_word,		// Stream to tiles
	output logic					busy,
	output logic					sending,
	output logic					end_send
);

	// Thread map lookup
	logic					lookup_req;
	mpu_pkg::thread_id_t	lookup_id;
	logic					lookup_ack;
	mpu_pkg::lookup_t		lookup_info;

	// Instruction fetch
	logic					mem_rd;
	mpu_pkg::mem_addr_t		mem_addr;
	mpu_pkg::instr_t		rd_word;

	thread_dispatch u_dispatch (
		.clock			(clock),
		.reset			(reset),
		.issue			(issue),
		.thread_id		(thread_id),
		.issue_no		(issue_no),
		.lookup_req		(lookup_req),
		.lookup_id		(lookup_id),
		.lookup_ack		(lookup_ack),
		.lookup_info	(lookup_info),
		.mem_rd			(mem_rd),
		.mem_addr		(mem_addr),
		.rd_word		(rd_word),
		.out_word		(out_word),
		.busy			(busy),
		.sending		(sending),
		.end_send		(end_send)
	);

	thread_map u_map (
		.clock			(clock),
		.reset			(reset),
		.map_write		(map_write),
		.lookup_req		(lookup_req),
		.lookup_id		(lookup_id),
		.lookup_ack		(lookup_ack),
		.lookup_info	(lookup_info)
	);

	instr_mem u_mem (
		.clock			(clock),
		.mem_write		(mem_write),
		.mem_rd			(mem_rd),
		.mem_addr		(mem_addr),
		.rd_word		(rd_word)
	);

endmodule

`default_nettype wire

// File: bench/dispatch_chk.sv
/*
 * Dispatcher protocol checks
 * Concurrent assertions bound into the dispatch FSM
 */

`timescale 1ns/10ps
`default_nettype none

module dispatch_chk (
	input  wire					clock,
	input  wire					reset,
	input  wire					end_send,
	input  wire					sending,
	input  wire					lookup_ack,
	input  wire					busy,
	input  mpu_pkg::instr_t		out_word
);

	int	assert_fails = 0;							// Failed assertion count

	// Last read happens in send_instrs and ends the burst
	assert property (@(posedge clock) disable iff (reset)
		end_send |-> (sending ##1 !busy))
		else begin
			$error("end_send outside send_instrs or not followed by idle");
			assert_fails++;
		end

	assert property (@(posedge clock) disable iff (reset) lookup_ack |=> !lookup_ack)
		else begin
			$error("lookup_ack high on two consecutive cycles");
			assert_fails++;
		end

	// Stream is quiet once the last word has drained
	assert property (@(posedge clock) disable iff (reset)
		($past(!busy) && $past(!busy, 2)) |-> !out_word.valid)
		else begin
			$error("valid output word while dispatcher idle");
			assert_fails++;
		end

endmodule

bind thread_dispatch dispatch_chk chk (
	.clock		(clock),
	.reset		(reset),
	.end_send	(end_send),
	.sending	(sending),
	.lookup_ack	(lookup_ack),
	.busy		(busy),
	.out_word	(out_word)
);

`default_nettype wire

// File: bench/dispatch_monitor.sv
/*
 * Dispatch stream monitor
 * Collects each output burst from its first valid header word
 * and compares it word by word against the expected stream.
 */

`timescale 1ns/10ps
`default_nettype none

module dispatch_monitor (
	input  wire					clock,
	input  wire					reset,
	input  mpu_pkg::instr_t		out_word,
	input  wire					busy,
	input  wire					sending,
	input  wire					end_send,
	output integer				done_count,		// Bursts finished
	output integer				fail_count,		// Bursts with a mismatch
	output integer				error_count		// Words outside any expected burst
);

	localparam int MAX_TESTS = 32;
	localparam int MAX_WORDS = 512;

	// Expected streams, filled in while the golden file is read
	logic [8*16-1:0]	names [0:MAX_TESTS-1];
	int					first_word [0:MAX_TESTS-1];
	int					word_count [0:MAX_TESTS-1];
	mpu_pkg::instr_t	exp_words [0:MAX_WORDS-1];
	int					num_tests = 0;
	int					num_words = 0;

	logic				in_burst;
	int					pos;						// Word index in burst
	logic				mismatch;
	mpu_pkg::instr_t	expected;
	logic				exp_busy;
	logic				exp_sending;
	logic				exp_end;

	task automatic add_test(input logic [8*16-1:0] name, input int count);
		names[num_tests]		= name;
		first_word[num_tests]	= num_words;
		word_count[num_tests]	= count;
		num_tests++;
	endtask

	task automatic add_word(input mpu_pkg::instr_t word);
		exp_words[num_words] = word;
		num_words++;
	endtask

	////////////////////////////////////////
	// Burst compare, sampled mid-cycle
	////////////////////////////////////////
	always @(negedge clock) begin
		if (reset) begin
			in_burst	= 1'b0;
			pos			= 0;
			mismatch	= 1'b0;
			done_count	= 0;
			fail_count	= 0;
			error_count	= 0;
		end
		else if (in_burst || out_word.valid) begin
			if (!in_burst && done_count >= num_tests) begin
				$display("Unexpected output word %h with no burst expected", out_word);
				error_count++;
			end
			else begin
				if (!in_burst) begin
					in_burst	= 1'b1;				// First header word
					pos			= 0;
					mismatch	= 1'b0;
				end
				expected = exp_words[first_word[done_count] + pos];
				// Reads run one cycle ahead of the program words
				exp_sending	= pos >= 2 && pos <= word_count[done_count] - 2;
				exp_end		= pos == word_count[done_count] - 2;
				exp_busy	= pos <= word_count[done_count] - 2;
				if (out_word !== expected && !mismatch) begin
					$display("Fail %0s expected %h actual %h",
						names[done_count], expected, out_word);
					mismatch = 1'b1;
				end
				if ({busy, sending, end_send} !== {exp_busy, exp_sending, exp_end}
					&& !mismatch) begin
					$display("Fail %0s busy/sending/end_send word %0d expected %b actual %b",
						names[done_count], pos, {exp_busy, exp_sending, exp_end},
						{busy, sending, end_send});
					mismatch = 1'b1;
				end
				pos++;
				if (pos == word_count[done_count]) begin
					if (mismatch) begin
						fail_count++;
					end
					else begin
						$display("Pass %0s", names[done_count]);
					end
					done_count++;
					in_burst = 1'b0;
				end
			end
		end
		else if (sending || end_send) begin
			$display("sending or end_send high while no burst is on the stream");
			error_count++;
		end
	end

endmodule

`default_nettype wire

// File: bench/dispatch_tb.sv
/*
 * Dispatch front end testbench
 * Loads thread map and instruction memory from the golden file,
 * issues each test thread with random idle gaps and leaves the
 * stream compare to the monitor.
 */

`timescale 1ns/10ps
`default_nettype none

module dispatch_tb;

	localparam int RESET_CYCLES	= 10;
	localparam int MAX_TESTS	= 32;

	logic					clock;
	logic					reset;
	logic					issue;
	mpu_pkg::thread_id_t	thread_id;
	mpu_pkg::issue_no_t		issue_no;
	mpu_pkg::map_write_t	map_write;
	mpu_pkg::mem_write_t	mem_write;
	mpu_pkg::instr_t		out_word;
	logic					busy;
	logic					sending;
	logic					end_send;
	integer					done_count;
	integer					fail_count;
	integer					error_count;

	// Parsed golden file
	mpu_pkg::map_write_t	map_loads [$];
	mpu_pkg::mem_write_t	mem_loads [$];
	mpu_pkg::thread_id_t	test_tid [0:MAX_TESTS-1];
	mpu_pkg::issue_no_t		test_issue [0:MAX_TESTS-1];
	logic					test_dup [0:MAX_TESTS-1];	// Extra strobe while busy
	int						test_len [0:MAX_TESTS-1];
	int						num_tests = 0;

	int						cycle_count = 0;
	int						cycle_limit = 100000;
	logic [7:0]				lfsr = 8'd7;

	mpu_dispatch uut (
		.clock		(clock),
		.reset		(reset),
		.issue		(issue),
		.thread_id	(thread_id),
		.issue_no	(issue_no),
		.map_write	(map_write),
		.mem_write	(mem_write),
		.out_word	(out_word),
		.busy		(busy),
		.sending	(sending),
		.end_send	(end_send)
	);

	dispatch_monitor mon (
		.clock			(clock),
		.reset			(reset),
		.out_word		(out_word),
		.busy			(busy),
		.sending		(sending),
		.end_send		(end_send),
		.done_count		(done_count),
		.fail_count		(fail_count),
		.error_count	(error_count)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("Run timed out after %0d cycles before all bursts were seen", cycle_count);
			$display("Simulation failed");
			$finish;
		end
	end

	// Galois LFSR, x^8 + x^6 + x^5 + x^4 + 1
	function automatic logic [7:0] next_lfsr(input logic [7:0] s);
		logic [7:0] n;
		n = s >> 1;
		if (s[0]) begin
			n = n ^ 8'hB8;
		end
		return n;
	endfunction

	// Idle gap of 0 to 7 cycles, one LFSR step per bit
	task automatic draw_gap(output int gap);
		gap = 0;
		for (int i = 0; i < 3; i++) begin
			lfsr = next_lfsr(lfsr);
			gap = (gap << 1) | lfsr[0];
		end
	endtask

	////////////////////////////////////////
	// Golden file reader
	////////////////////////////////////////
	task automatic read_golden(output logic ok);
		int					fd;
		int					code;
		logic [8*16-1:0]	tok;
		logic [8*16-1:0]	name;
		logic [8*256-1:0]	rest;
		logic [31:0]		f1;
		logic [31:0]		f2;
		logic [31:0]		f3;
		logic [31:0]		f4;
		logic [32:0]		w;
		mpu_pkg::map_write_t	mw;
		mpu_pkg::mem_write_t	ww;
		ok = 1'b1;
		fd = $fopen("bench/dispatch_golden.txt", "r");
		if (fd == 0) begin
			$display("Cannot open golden file bench/dispatch_golden.txt");
			ok = 1'b0;
		end
		else begin
			while (!$feof(fd)) begin
				code = $fscanf(fd, "%s", tok);
				if (code == 1) begin
					if (tok == "#") begin
						code = $fgets(rest, fd);			// Column notes
					end
					else if (tok == "M") begin
						code = $fscanf(fd, "%h %h %h", f1, f2, f3);
						mw.en			= 1'b1;
						mw.tid			= mpu_pkg::thread_id_t'(f1);
						mw.info.base	= mpu_pkg::mem_addr_t'(f2);
						mw.info.length	= mpu_pkg::prog_len_t'(f3);
						map_loads.push_back(mw);
					end
					else if (tok == "W") begin
						code = $fscanf(fd, "%h %h", f1, w);
						ww.en	= 1'b1;
						ww.addr	= mpu_pkg::mem_addr_t'(f1);
						ww.word	= w;
						mem_loads.push_back(ww);
					end
					else if (tok == "T" && num_tests < MAX_TESTS) begin
						code = $fscanf(fd, "%s %h %h %h %h", name, f1, f2, f3, f4);
						test_tid[num_tests]		= mpu_pkg::thread_id_t'(f1);
						test_issue[num_tests]	= mpu_pkg::issue_no_t'(f2);
						test_dup[num_tests]		= f3[0];
						test_len[num_tests]		= f4;
						mon.add_test(name, f4);
						for (int k = 0; k < f4; k++) begin
							code = $fscanf(fd, "%h", w);
							mon.add_word(w);
						end
						num_tests++;
					end
					else begin
						$display("Golden file line of unknown kind %0s", tok);
						ok = 1'b0;
					end
				end
			end
			$fclose(fd);
			if (num_tests == 0) begin
				$display("Golden file holds no tests");
				ok = 1'b0;
			end
		end
	endtask

	////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////
	task automatic issue_thread(input int t);
		@(posedge clock);
		issue		<= 1'b1;
		thread_id	<= test_tid[t];
		issue_no	<= test_issue[t];
		@(posedge clock);
		issue		<= 1'b0;
		thread_id	<= ~test_tid[t];					// Inputs move mid-burst
		issue_no	<= ~test_issue[t];
		if (test_dup[t]) begin
			repeat (2) @(posedge clock);
			issue		<= 1'b1;
			thread_id	<= test_tid[t] + 1'b1;
			issue_no	<= test_issue[t] + 1'b1;
			@(posedge clock);
			issue		<= 1'b0;
		end
		do begin
			@(negedge clock);
		end while (busy);
	endtask

	task automatic run_all();
		int gap;
		repeat (RESET_CYCLES) @(posedge clock);
		reset <= 1'b0;
		foreach (map_loads[i]) begin
			@(posedge clock);
			map_write <= map_loads[i];
		end
		foreach (mem_loads[i]) begin
			@(posedge clock);
			map_write <= '0;
			mem_write <= mem_loads[i];
		end
		@(posedge clock);
		map_write <= '0;
		mem_write <= '0;
		for (int t = 0; t < num_tests; t++) begin
			issue_thread(t);
			draw_gap(gap);
			repeat (gap) @(posedge clock);
		end
		while (done_count < num_tests) begin
			@(negedge clock);
		end
		repeat (8) @(posedge clock);					// Window for a stray burst
		$display("Tests done %0d, failed %0d, stray words %0d, assertion failures %0d",
			done_count, fail_count, error_count, uut.u_dispatch.chk.assert_fails);
		if (fail_count == 0 && error_count == 0 && done_count == num_tests
			&& uut.u_dispatch.chk.assert_fails == 0) begin
			$display("Simulation passed");
		end
		else begin
			$display("Simulation failed");
		end
		$finish;
	endtask

	initial begin
		logic ok;
		reset		= 1'b1;
		issue		= 1'b0;
		thread_id	= '0;
		issue_no	= '0;
		map_write	= '0;
		mem_write	= '0;
		read_golden(ok);
		// Per test: strobe, lookup and header 7, L+1 words, gap up to 7, margin
		cycle_limit = RESET_CYCLES + map_loads.size() + mem_loads.size() + 32;
		for (int t = 0; t < num_tests; t++) begin
			cycle_limit = cycle_limit + test_len[t] + 16;
		end
		if (!ok) begin
			$display("Simulation failed");
			$finish;
		end
		else begin
			run_all();
		end
	end

endmodule

`default_nettype wire

// File: list.f
+incdir+include
hdl/mpu_pkg.sv
hdl/thread_map.sv
hdl/instr_mem.sv
hdl/thread_dispatch.sv
hdl/mpu_dispatch.sv
bench/dispatch_chk.sv
bench/dispatch_monitor.sv
bench/dispatch_tb.sv

// File: bench/dispatch_golden.txt
# M tid base length | W addr word(valid+data) | T name tid issue dup count words...
# All numbers hex, count is the burst length L+4
M 1 10 00
M 2 20 05
M 3 30 03
M 4 22 04
M 5 40 01
M 6 50 02
M 7 23 01
W 10 1C0DE0010
W 20 1C0DE0020
W 21 1C0DE0021
W 22 1C0DE0022
W 23 1C0DE0023
W 24 1C0DE0024
W 25 1C0DE0025
W 26 1C0DE0026
W 30 1C0DE0030
W 31 1C0DE0031
W 32 0DEADBEEF
W 33 1C0DE0033
W 40 1C0DE0040
W 41 1C0DE0041
W 50 1C0DE0050
W 51 1C0DE0051
W 52 1C0DE0052
T len_zero 1 05 0 4 100000001 100000005 100000000 1C0DE0010
T long_prog 2 0A 0 9 100000002 10000000A 100000005 1C0DE0020 1C0DE0021 1C0DE0022 1C0DE0023 1C0DE0024 1C0DE0025
T invalid_slot 3 11 0 7 100000003 100000011 100000003 1C0DE0030 1C0DE0031 0DEADBEEF 1C0DE0033
T overlap_a 4 12 0 8 100000004 100000012 100000004 1C0DE0022 1C0DE0023 1C0DE0024 1C0DE0025 1C0DE0026
T overlap_b 2 13 0 9 100000002 100000013 100000005 1C0DE0020 1C0DE0021 1C0DE0022 1C0DE0023 1C0DE0024 1C0DE0025
T drop_second 5 20 1 5 100000005 100000020 100000001 1C0DE0040 1C0DE0041
T b2b_a 6 21 0 6 100000006 100000021 100000002 1C0DE0050 1C0DE0051 1C0DE0052
T b2b_b 7 22 0 5 100000007 100000022 100000001 1C0DE0023 1C0DE0024
T b2b_c 1 3F 0 4 100000001 10000003F 100000000 1C0DE0010
